//--- logic/vred_isa_pkg.sv
/*
 * Vector reduction ISA encodings
 * Reduction opcodes, element width codes and the combining
 * operation kinds shared by decode and the lane trees
 */

package vred_isa_pkg;

    // Reduction opcodes
    typedef enum logic [2:0] {
        VREDSUM  = 3'd0,
        VREDAND  = 3'd1,
        VREDOR   = 3'd2,
        VREDXOR  = 3'd3,
        VREDMIN  = 3'd4,
        VREDMINU = 3'd5,
        VREDMAX  = 3'd6,
        VREDMAXU = 3'd7
    } red_op_e;

    // Element width, vsew encoding; code 3 is treated as EW32
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vsew_e;

    // Combining operation; signedness travels beside it
    typedef enum logic [2:0] {
        SUM = 3'd0,
        AND = 3'd1,
        OR  = 3'd2,
        XOR = 3'd3,
        MIN = 3'd4,
        MAX = 3'd5
    } red_kind_e;

endpackage

//--- logic/vred_arch_pkg.sv
/*
 * Vector reduction datapath sizes
 * Scalar and result width, default vector length and
 * the element widths of the three lane trees
 */

package vred_arch_pkg;

    // Scalar seed and result width
    localparam int XLEN = 32;

    // Default vector register length in bits
    localparam int DEFAULT_VLEN = 64;

    // Element widths, one per lane tree
    localparam int ELEM_W8  = 8;
    localparam int ELEM_W16 = 16;
    localparam int ELEM_W32 = 32;

endpackage

//--- logic/vred_decode.sv
/*
 * Reduction decode
 * Maps the opcode to a combining kind and signedness and
 * builds the active-element vector from vl and the mask
 */

`timescale 1ns/1ps

module vred_decode #(
    parameter int VLEN = 64
) (
    input  vred_isa_pkg::red_op_e   op_i,
    input  logic [$clog2(VLEN/8):0] vl_i,
    input  logic                    vm_i,
    input  logic [VLEN/8-1:0]       mask_i,
    output vred_isa_pkg::red_kind_e kind_o,
    output logic                    is_signed_o,
    output logic [VLEN/8-1:0]       active_o
);

    localparam int NUM_IDX = VLEN / 8;

    always_comb begin
        kind_o      = vred_isa_pkg::SUM;
        is_signed_o = 1'b0;
        unique case (op_i)
            vred_isa_pkg::VREDSUM:  kind_o = vred_isa_pkg::SUM;
            vred_isa_pkg::VREDAND:  kind_o = vred_isa_pkg::AND;
            vred_isa_pkg::VREDOR:   kind_o = vred_isa_pkg::OR;
            vred_isa_pkg::VREDXOR:  kind_o = vred_isa_pkg::XOR;
            vred_isa_pkg::VREDMIN: begin
                kind_o      = vred_isa_pkg::MIN;
                is_signed_o = 1'b1;
            end
            vred_isa_pkg::VREDMINU: kind_o = vred_isa_pkg::MIN;
            vred_isa_pkg::VREDMAX: begin
                kind_o      = vred_isa_pkg::MAX;
                is_signed_o = 1'b1;
            end
            vred_isa_pkg::VREDMAXU: kind_o = vred_isa_pkg::MAX;
            default:                kind_o = vred_isa_pkg::SUM;
        endcase
    end

    // Element i takes part when below vl and unmasked
    always_comb begin
        for (int i = 0; i < NUM_IDX; i++) begin
            active_o[i] = (i < int'(vl_i)) && (vm_i || mask_i[i]);
        end
    end

endmodule

//--- logic/vred_lane_tree.sv
/*
 * Reduction tree for one element width
 * Fills inactive elements with the identity of the kind,
 * reduces them in a balanced tree and folds in the scalar seed
 */

`timescale 1ns/1ps

module vred_lane_tree #(
    parameter int VLEN = 64,
    parameter int SEW  = 8
) (
    input  logic [VLEN-1:0]          vec_i,
    input  logic [SEW-1:0]           scalar_i,
    input  vred_isa_pkg::red_kind_e  kind_i,
    input  logic                     is_signed_i,
    input  logic [VLEN/SEW-1:0]      active_i,
    output logic [SEW-1:0]           result_o
);

    localparam int NUM_ELEM = VLEN / SEW;
    localparam int LEVELS   = $clog2(NUM_ELEM);
    localparam int TREE_N   = 1 << LEVELS;

    // ********************
    // Combine operation
    // ********************
    function automatic logic [SEW-1:0] combine(
        input logic [SEW-1:0]          a,
        input logic [SEW-1:0]          b,
        input vred_isa_pkg::red_kind_e kind,
        input logic                    sgn
    );
        logic a_lt_b;
        a_lt_b = sgn ? ($signed(a) < $signed(b)) : (a < b);
        case (kind)
            vred_isa_pkg::SUM: return a + b;
            vred_isa_pkg::AND: return a & b;
            vred_isa_pkg::OR:  return a | b;
            vred_isa_pkg::XOR: return a ^ b;
            vred_isa_pkg::MIN: return a_lt_b ? a : b;
            vred_isa_pkg::MAX: return a_lt_b ? b : a;
            default:           return a + b;
        endcase
    endfunction

    // ********************
    // Identity fill
    // ********************
    logic [SEW-1:0] ident;

    always_comb begin
        case (kind_i)
            vred_isa_pkg::AND: ident = '1;
            vred_isa_pkg::MIN: begin
                // Largest signed value, or all ones when unsigned
                ident = is_signed_i ? {1'b0, {(SEW-1){1'b1}}} : '1;
            end
            vred_isa_pkg::MAX: begin
                ident = is_signed_i ? {1'b1, {(SEW-1){1'b0}}} : '0;
            end
            default:           ident = '0;
        endcase
    end

    // ********************
    // Balanced tree
    // ********************
    // Heap layout, node k reduces nodes 2k+1 and 2k+2
    logic [SEW-1:0] node [2*TREE_N-1];

    for (genvar i = 0; i < TREE_N; i++) begin : g_leaf
        if (i < NUM_ELEM) begin : g_elem
            assign node[TREE_N-1+i] = active_i[i] ? vec_i[i*SEW +: SEW] : ident;
        end else begin : g_pad
            // Padding up to a power of two
            assign node[TREE_N-1+i] = ident;
        end
    end

    for (genvar k = 0; k < TREE_N-1; k++) begin : g_node
        assign node[k] = combine(node[2*k+1], node[2*k+2], kind_i, is_signed_i);
    end

    // Scalar seed joins at the root
    assign result_o = combine(node[0], scalar_i, kind_i, is_signed_i);

endmodule

//--- logic/vred_result.sv
/*
 * Reduction result stage
 * Picks the tree output for the element width, zero-extends
 * it to the scalar width and registers it every clock
 */

`timescale 1ns/1ps

module vred_result #(
    parameter int VLEN = 64
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  vred_isa_pkg::vsew_e            vsew_i,
    input  logic [7:0]                     res8_i,
    input  logic [15:0]                    res16_i,
    input  logic [31:0]                    res32_i,
    output logic [vred_arch_pkg::XLEN-1:0] result_o
);

    localparam int XW = vred_arch_pkg::XLEN;

    // The 32-bit tree needs at least one whole element
    if (VLEN % vred_arch_pkg::ELEM_W32 != 0) begin : g_vlen_check
        $error("VLEN must be a multiple of 32");
    end

    logic [XW-1:0] sel;

    always_comb begin
        case (vsew_i)
            vred_isa_pkg::EW8:  sel = {{(XW-8){1'b0}}, res8_i};
            vred_isa_pkg::EW16: sel = {{(XW-16){1'b0}}, res16_i};
            // EW32 and the unused code
            default:            sel = {{(XW-32){1'b0}}, res32_i};
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end else begin
            result_o <= sel;
        end
    end

endmodule

//--- logic/vred_unit.sv
/*
 * Vector reduction unit
 * Reduces one vector operand with a scalar seed at 8, 16 or
 * 32-bit elements; result valid one cycle after the inputs
 */

`timescale 1ns/1ps

module vred_unit #(
    parameter int VLEN = vred_arch_pkg::DEFAULT_VLEN
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  vred_isa_pkg::red_op_e          op_i,
    input  vred_isa_pkg::vsew_e            vsew_i,
    input  logic [VLEN-1:0]                vec_i,
    input  logic [vred_arch_pkg::XLEN-1:0] scalar_i,
    input  logic [$clog2(VLEN/8):0]        vl_i,
    input  logic                           vm_i,
    input  logic [VLEN/8-1:0]              mask_i,
    output logic [vred_arch_pkg::XLEN-1:0] result_o
);

    localparam int W8  = vred_arch_pkg::ELEM_W8;
    localparam int W16 = vred_arch_pkg::ELEM_W16;
    localparam int W32 = vred_arch_pkg::ELEM_W32;

    vred_isa_pkg::red_kind_e kind;
    logic                    is_signed;
    logic [VLEN/8-1:0]       active;
    logic [W8-1:0]           res8;
    logic [W16-1:0]          res16;
    logic [W32-1:0]          res32;

    vred_decode #(.VLEN(VLEN)) i_decode (
        .op_i       (op_i),
        .vl_i       (vl_i),
        .vm_i       (vm_i),
        .mask_i     (mask_i),
        .kind_o     (kind),
        .is_signed_o(is_signed),
        .active_o   (active)
    );

    // ********************
    // Lane trees
    // ********************
    vred_lane_tree #(.VLEN(VLEN), .SEW(W8)) i_tree8 (
        .vec_i      (vec_i),
        .scalar_i   (scalar_i[W8-1:0]),
        .kind_i     (kind),
        .is_signed_i(is_signed),
        .active_i   (active[VLEN/W8-1:0]),
        .result_o   (res8)
    );

    vred_lane_tree #(.VLEN(VLEN), .SEW(W16)) i_tree16 (
        .vec_i      (vec_i),
        .scalar_i   (scalar_i[W16-1:0]),
        .kind_i     (kind),
        .is_signed_i(is_signed),
        .active_i   (active[VLEN/W16-1:0]),
        .result_o   (res16)
    );

    vred_lane_tree #(.VLEN(VLEN), .SEW(W32)) i_tree32 (
        .vec_i      (vec_i),
        .scalar_i   (scalar_i[W32-1:0]),
        .kind_i     (kind),
        .is_signed_i(is_signed),
        .active_i   (active[VLEN/W32-1:0]),
        .result_o   (res32)
    );

    vred_result #(.VLEN(VLEN)) i_result (
        .clk     (clk),
        .reset_n (reset_n),
        .vsew_i  (vsew_i),
        .res8_i  (res8),
        .res16_i (res16),
        .res32_i (res32),
        .result_o(result_o)
    );

endmodule

//--- sim/vred_properties.sv
/*
 * Reduction unit properties
 * Result is cleared in reset and zero-extended for narrow elements
 */

`timescale 1ns/1ps

module vred_properties (
    input logic                           clk,
    input logic                           reset_n,
    input vred_isa_pkg::vsew_e            vsew_i,
    input logic [vred_arch_pkg::XLEN-1:0] result_o
);

    localparam int XW = vred_arch_pkg::XLEN;

    a_reset_clear: assert property (@(posedge clk) !reset_n |-> result_o == '0)
        else $error("result_o not zero during reset");

    a_ew8_zext: assert property (@(posedge clk) disable iff (!reset_n)
        vsew_i == vred_isa_pkg::EW8 |=> result_o[XW-1:8] == '0)
        else $error("upper bits of result_o set after an 8-bit reduction");

    a_ew16_zext: assert property (@(posedge clk) disable iff (!reset_n)
        vsew_i == vred_isa_pkg::EW16 |=> result_o[XW-1:16] == '0)
        else $error("upper bits of result_o set after a 16-bit reduction");

endmodule

//--- sim/tb_vred.sv
/*
 * Testbench for the vector reduction unit
 * Directed and LFSR driven reductions, one per cycle, checked
 * one cycle later against a reference model
 */

`timescale 1ns/1ps

module tb_vred;

    localparam int VLEN       = 64;
    localparam int XLEN       = vred_arch_pkg::XLEN;
    localparam int NIDX       = VLEN / 8;
    localparam int VLW        = $clog2(NIDX) + 1;
    localparam int RESET_CYC  = 4;
    localparam int N_DIRECTED = 32;
    localparam int N_RANDOM   = 400;
    localparam int TEST_CYC   = RESET_CYC + N_DIRECTED + N_RANDOM + 4;
    localparam int CLK_PERIOD = 40;

    logic                  clk;
    logic                  reset_n;
    vred_isa_pkg::red_op_e op;
    vred_isa_pkg::vsew_e   vsew;
    logic [VLEN-1:0]       vec;
    logic [XLEN-1:0]       scalar;
    logic [VLW-1:0]        vl;
    logic                  vm;
    logic [NIDX-1:0]       mask;
    logic [XLEN-1:0]       result;

    logic [31:0]           lfsr;
    logic [XLEN-1:0]       expected;
    logic                  have_exp;
    int                    checks;
    int                    errors;

    vred_unit #(.VLEN(VLEN)) i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .op_i    (op),
        .vsew_i  (vsew),
        .vec_i   (vec),
        .scalar_i(scalar),
        .vl_i    (vl),
        .vm_i    (vm),
        .mask_i  (mask),
        .result_o(result)
    );

    bind vred_unit vred_properties i_props (
        .clk     (clk),
        .reset_n (reset_n),
        .vsew_i  (vsew_i),
        .result_o(result_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ********************
    // Stimulus helpers
    // ********************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int elem_count(input logic [1:0] vsew_m);
        case (vsew_m)
            2'b00:   return VLEN / 8;
            2'b01:   return VLEN / 16;
            default: return VLEN / 32;
        endcase
    endfunction

    function automatic longint sign_extend(input logic [31:0] v, input int w);
        if (v[w-1]) begin
            return longint'(v) - (longint'(1) << w);
        end
        return longint'(v);
    endfunction

    // ********************
    // Reference model
    // ********************
    function automatic logic [XLEN-1:0] model_reduce(
        input logic [2:0]      op_m,
        input logic [1:0]      vsew_m,
        input logic [VLEN-1:0] vec_m,
        input logic [XLEN-1:0] scalar_m,
        input logic [VLW-1:0]  vl_m,
        input logic            vm_m,
        input logic [NIDX-1:0] mask_m
    );
        int          sew;
        logic [31:0] wmask;
        logic [31:0] acc;
        logic [31:0] elem;
        longint      sa;
        longint      se;
        sew   = VLEN / elem_count(vsew_m);
        wmask = (sew == 32) ? 32'hFFFF_FFFF : ((32'd1 << sew) - 32'd1);
        acc   = scalar_m & wmask;
        for (int i = 0; i < elem_count(vsew_m); i++) begin
            elem = 32'(vec_m >> (i * sew)) & wmask;
            sa   = sign_extend(acc, sew);
            se   = sign_extend(elem, sew);
            if ((i < int'(vl_m)) && (vm_m || mask_m[i])) begin
                case (op_m)
                    vred_isa_pkg::VREDSUM:  acc = (acc + elem) & wmask;
                    vred_isa_pkg::VREDAND:  acc = acc & elem;
                    vred_isa_pkg::VREDOR:   acc = acc | elem;
                    vred_isa_pkg::VREDXOR:  acc = acc ^ elem;
                    vred_isa_pkg::VREDMIN:  acc = (se < sa) ? elem : acc;
                    vred_isa_pkg::VREDMINU: acc = (elem < acc) ? elem : acc;
                    vred_isa_pkg::VREDMAX:  acc = (se > sa) ? elem : acc;
                    default:                acc = (elem > acc) ? elem : acc;
                endcase
            end
        end
        return acc;
    endfunction

    task automatic compare(input string name, input logic [XLEN-1:0] exp_v,
                           input logic [XLEN-1:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("mismatch %s at %0t: expected %h, got %h", name, $time, exp_v, act_v);
        end
    endtask

    // Checks the previous operation, then drives the next one
    task automatic step_op(input logic [2:0] op_v, input logic [1:0] vsew_v,
                           input logic [VLEN-1:0] vec_v, input logic [XLEN-1:0] scalar_v,
                           input logic [VLW-1:0] vl_v, input logic vm_v,
                           input logic [NIDX-1:0] mask_v);
        @(posedge clk);
        #2;
        if (have_exp) begin
            compare("result_o", expected, result);
        end
        op       = vred_isa_pkg::red_op_e'(op_v);
        vsew     = vred_isa_pkg::vsew_e'(vsew_v);
        vec      = vec_v;
        scalar   = scalar_v;
        vl       = vl_v;
        vm       = vm_v;
        mask     = mask_v;
        expected = model_reduce(op_v, vsew_v, vec_v, scalar_v, vl_v, vm_v, mask_v);
        have_exp = 1'b1;
    endtask

    task automatic directed_tests();
        for (int w = 0; w < 3; w++) begin
            // Top bits set so signed and unsigned results differ
            for (int o = 4; o < 8; o++) begin
                step_op(3'(o), 2'(w), 64'h80FF_7F01_C000_8001, 32'h0000_0040,
                        VLW'(elem_count(2'(w))), 1'b1, '0);
            end
            // AND with inactive elements
            step_op(3'd1, 2'(w), 64'h00F0_F0F0_0F0F_F0F0, 32'hFFFF_FFFF, 4'd3, 1'b0, 8'h05);
            step_op(3'd2, 2'(w), 64'h0123_4567_89AB_CDEF, 32'h1000_0001,
                    VLW'(elem_count(2'(w))), 1'b1, '0);
            step_op(3'd3, 2'(w), 64'hFEDC_BA98_7654_3210, 32'h5A5A_A5A5,
                    VLW'(elem_count(2'(w))), 1'b0, 8'h6C);
            // Empty vector length, then an all-zero mask
            step_op(3'd0, 2'(w), 64'h1111_2222_3333_4444, 32'hDEAD_BEEF, 4'd0, 1'b1, 8'hFF);
            step_op(3'd4, 2'(w), 64'h8000_8000_8000_8000, 32'h1357_2468, 4'd0, 1'b0, 8'hFF);
            step_op(3'd0, 2'(w), 64'h1111_2222_3333_4444, 32'hCAFE_F00D,
                    VLW'(elem_count(2'(w))), 1'b0, 8'h00);
        end
        // Mask ignored while vm is high
        step_op(3'd0, 2'b01, 64'h0102_0304_0506_0708, 32'h0000_0100, 4'd4, 1'b1, 8'h00);
        step_op(3'd0, 2'b01, 64'h0102_0304_0506_0708, 32'h0000_0100, 4'd4, 1'b1, 8'hA5);
    endtask

    task automatic random_tests();
        logic [63:0] r;
        logic [2:0]  op_v;
        logic [1:0]  vsew_v;
        logic [63:0] vec_v;
        logic [31:0] scalar_v;
        logic [VLW-1:0] vl_v;
        logic        vm_v;
        logic [NIDX-1:0] mask_v;
        for (int n = 0; n < N_RANDOM; n++) begin
            take_bits(3, r);
            op_v = r[2:0];
            take_bits(2, r);
            vsew_v = r[1:0];
            take_bits(64, r);
            vec_v = r;
            take_bits(32, r);
            scalar_v = r[31:0];
            take_bits(VLW, r);
            vl_v = VLW'(int'(r[VLW-1:0]) % (elem_count(vsew_v) + 1));
            take_bits(1, r);
            vm_v = r[0];
            take_bits(NIDX, r);
            mask_v = r[NIDX-1:0];
            step_op(op_v, vsew_v, vec_v, scalar_v, vl_v, vm_v, mask_v);
        end
    endtask

    // ********************
    // Main sequence
    // ********************
    initial begin
        clk      = 1'b0;
        reset_n  = 1'b0;
        op       = vred_isa_pkg::VREDSUM;
        vsew     = vred_isa_pkg::EW8;
        vec      = '0;
        // Nonzero seed so only the reset keeps the register at zero
        scalar   = 32'hC3A5_5A3C;
        vl       = '0;
        vm       = 1'b0;
        mask     = '0;
        lfsr     = 32'd81;
        expected = '0;
        have_exp = 1'b0;
        checks   = 0;
        errors   = 0;
        repeat (RESET_CYC) begin
            @(posedge clk);
            #2;
            compare("result_o", '0, result);
        end
        reset_n = 1'b1;
        #1;
        compare("result_o", '0, result);
        // First edge out of reset loads the idle inputs
        expected = model_reduce(op, vsew, vec, scalar, vl, vm, mask);
        have_exp = 1'b1;
        directed_tests();
        random_tests();
        @(posedge clk);
        #2;
        compare("result_o", expected, result);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYC + 20) * CLK_PERIOD);
        errors++;
        $display("error: run did not finish within %0d clock cycles", TEST_CYC + 20);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

endmodule

//--- tb.f
logic/vred_isa_pkg.sv
logic/vred_arch_pkg.sv
logic/vred_decode.sv
logic/vred_lane_tree.sv
logic/vred_result.sv
logic/vred_unit.sv
sim/vred_properties.sv
sim/tb_vred.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vector reduction testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_vred -o vsim_tb_vred

# The simulation may stop early on an assertion, so its status is read from the log
./obj_dir/vsim_tb_vred > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
